//--- src/msx_video_pkg.sv
// MSX video config package with settings enums, bus structs and default constants
package msx_video_pkg;

   // ======================================================================
   // Status word and defaults
   // ======================================================================

   // Width of the OSD status word
   localparam int unsigned STATUS_W = 64;

   // Aspect numbers for the original 4:3 picture
   localparam logic [12:0] DEF_ARX_NATIVE = 13'd400;
   // Narrower picture for 600/800 line displays
   localparam logic [12:0] DEF_ARX_WIDE   = 13'd340;
   localparam logic [12:0] DEF_ARY_NATIVE = 13'd300;

   // Loader index of a cassette file
   localparam logic [5:0]  DEF_CAS_INDEX  = 6'd8;

   // ======================================================================
   // Setting enums
   // ======================================================================

   // Status bits 2:1
   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } aspect_e;

   // Status bits 6:5, same coding as the scaler
   typedef enum logic [1:0] {
      SCALE_NORMAL       = 2'd0,
      SCALE_VINT         = 2'd1,
      SCALE_NARROW_HVINT = 2'd2,
      SCALE_WIDE_HVINT   = 2'd3
   } scale_e;

   // Status bit 8
   typedef enum logic {
      TAPE_SRC_FILE = 1'b0,
      TAPE_SRC_ADC  = 1'b1
   } tape_src_e;

   // ======================================================================
   // Bus structs
   // ======================================================================

   // Decoded OSD settings, 10 bits
   typedef struct packed {
      aspect_e    aspect;
      logic [1:0] scanlines;
      scale_e     scale;
      logic       vcrop_en;
      tape_src_e  tape_src;
      logic       tape_rewind;
      logic       scandoubler;
   } osd_cfg_t;

   // Connected HDMI display size, 24 bits
   typedef struct packed {
      logic [11:0] width;
      logic [11:0] height;
   } hdmi_size_t;

   // Crop lookup result, 11 bits
   typedef struct packed {
      logic [9:0] vcrop;
      logic       wide_mode;
   } crop_t;

   // Settings for the scaler, 40 bits
   typedef struct packed {
      logic [12:0] arx;
      logic [12:0] ary;
      logic [9:0]  crop_size;
      scale_e      scale;
      logic [1:0]  scanlines;
   } video_cfg_t;

endpackage

//--- src/osd_status_decode.sv
// OSD status decoder: typed video/tape settings and registered core reset
module osd_status_decode (
   input  logic                                CLK_VIDEO,
   input  logic                                arst_n,
   input  logic [msx_video_pkg::STATUS_W-1:0] status,
   input  logic                                forced_scandoubler,
   input  logic                                ext_reset,
   input  logic                                cart_reset,
   output msx_video_pkg::osd_cfg_t             cfg,
   output logic                                core_reset
);

   import msx_video_pkg::*;

   // ======================================================================
   // Status word fields
   // ======================================================================

   // Bit 0 reset, bit 10 reset and detach cartridge
   logic       reset_req;
   // Any scanline level forces the scandoubler path
   logic [1:0] scanline_lvl;

   assign scanline_lvl = status[4:3];
   assign reset_req    = ext_reset | status[0] | status[10] | cart_reset;

   always_comb begin
      // Aspect ratio menu, 2 bits
      cfg.aspect      = aspect_e'(status[2:1]);
      // Scanlines off/25/50/75
      cfg.scanlines   = scanline_lvl;
      // Scaler integer modes
      cfg.scale       = scale_e'(status[6:5]);
      // Vertical crop on
      cfg.vcrop_en    = status[7];
      // File or ADC tape input
      cfg.tape_src    = tape_src_e'(status[8]);
      // Rewind trigger from the menu
      cfg.tape_rewind = status[9];
      // Scandoubler active, picture not upscaled
      cfg.scandoubler = forced_scandoubler | (|scanline_lvl);
   end

   // ======================================================================
   // Core reset register
   // ======================================================================

   // Held high through arst_n
   // One cycle behind its sources on both edges
   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         core_reset <= 1'b1;
      end else begin
         core_reset <= reset_req;
      end
   end

endmodule

//--- src/crop_select.sv
// Vertical crop lookup from the connected HDMI resolution
module crop_select (
   input  logic                      CLK_VIDEO,
   input  logic                      arst_n,
   input  msx_video_pkg::hdmi_size_t hdmi,
   input  msx_video_pkg::osd_cfg_t   cfg,
   output msx_video_pkg::crop_t      crop
);

   import msx_video_pkg::*;

   // Height plus half height, one extra bit against overflow
   logic [12:0] h_one_half;
   // Display at least 3:2 wide
   logic        wide_fit;
   // Display wide enough for the 4:3 big modes
   logic        big_fit;
   crop_t       crop_d;

   assign h_one_half = {1'b0, hdmi.height} + {2'b00, hdmi.height[11:1]};
   assign wide_fit   = {1'b0, hdmi.width} >= h_one_half;
   assign big_fit    = hdmi.width >= 12'd1440;

   // ======================================================================
   // Lookup table
   // ======================================================================

   always_comb begin
      crop_d = '0;
      // Scandoubler output is never cropped
      if (!cfg.scandoubler) begin
         if (wide_fit) begin
            case (hdmi.height)
               12'd480: crop_d.vcrop = 10'd240;
               12'd600: begin
                  // 3x200 lines, needs the narrower picture
                  crop_d.vcrop     = 10'd200;
                  crop_d.wide_mode = 1'b1;
               end
               12'd720: crop_d.vcrop = 10'd240;
               // NTSC shows only 250 lines here
               12'd768: crop_d.vcrop = 10'd256;
               12'd800: begin
                  // 4x200 lines
                  crop_d.vcrop     = 10'd200;
                  crop_d.wide_mode = 1'b1;
               end
               12'd1080: crop_d.vcrop = 10'd216;
               12'd1200: crop_d.vcrop = 10'd240;
               default:  crop_d = '0;
            endcase
         end else if (big_fit) begin
            // 1920x1440 and 2048x1536 are 4:3, missed by the 3:2 test
            case (hdmi.height)
               12'd1440: crop_d.vcrop = 10'd240;
               12'd1536: crop_d.vcrop = 10'd256;
               default:  crop_d = '0;
            endcase
         end
      end
   end

   // ======================================================================
   // Output register
   // ======================================================================

   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         crop <= '0;
      end else begin
         crop <= crop_d;
      end
   end

endmodule

//--- src/aspect_result.sv
// Aspect ratio, crop size, scale and scanline outputs for the scaler
module aspect_result #(
   parameter logic [12:0] ARX_NATIVE = msx_video_pkg::DEF_ARX_NATIVE,
   parameter logic [12:0] ARX_WIDE   = msx_video_pkg::DEF_ARX_WIDE,
   parameter logic [12:0] ARY_NATIVE = msx_video_pkg::DEF_ARY_NATIVE
) (
   input  logic                      CLK_VIDEO,
   input  logic                      arst_n,
   input  msx_video_pkg::crop_t      crop,
   input  msx_video_pkg::osd_cfg_t   cfg,
   output msx_video_pkg::video_cfg_t video_cfg
);

   import msx_video_pkg::*;

   // Narrow picture only when crop is actually applied
   logic       wide;
   video_cfg_t video_cfg_d;

   assign wide = crop.wide_mode & cfg.vcrop_en;

   always_comb begin
      // Original aspect sends real ratio numbers
      if (cfg.aspect == AR_ORIGINAL) begin
         video_cfg_d.arx = wide ? ARX_WIDE : ARX_NATIVE;
         video_cfg_d.ary = ARY_NATIVE;
      end else begin
         // Other modes select scaler preset 0..2, ary zero
         video_cfg_d.arx = {11'd0, cfg.aspect} - 13'd1;
         video_cfg_d.ary = 13'd0;
      end
      video_cfg_d.crop_size = cfg.vcrop_en ? crop.vcrop : 10'd0;
      video_cfg_d.scale     = cfg.scale;
      video_cfg_d.scanlines = cfg.scanlines;
   end

   // ======================================================================
   // Output register
   // ======================================================================

   always_ff @(posedge CLK_VIDEO or negedge arst_n) begin
      if (!arst_n) begin
         video_cfg <= '0;
      end else begin
         video_cfg <= video_cfg_d;
      end
   end

endmodule

//--- src/tape_route.sv
// Tape input routing, cassette play/rewind and cassette download wait
module tape_route #(
   parameter logic [5:0] CAS_INDEX = msx_video_pkg::DEF_CAS_INDEX
) (
   input  msx_video_pkg::osd_cfg_t cfg,
   input  logic                    ioctl_download,
   input  logic [5:0]              ioctl_index,
   input  logic                    cas_ready,
   input  logic                    cas_bit,
   input  logic                    adc_bit,
   input  logic                    adc_active,
   input  logic                    cas_motor,
   input  logic                    core_reset,
   output logic                    tape_in,
   output logic                    cas_play,
   output logic                    cas_rewind,
   output logic                    ioctl_wait
);

   import msx_video_pkg::*;

   // Cassette file being loaded into the buffer
   logic cas_dl;

   assign cas_dl = ioctl_download & (ioctl_index == CAS_INDEX);

   // ADC bit only counts while the ADC sees a signal
   assign tape_in = (cfg.tape_src == TAPE_SRC_FILE) ? cas_bit : (adc_bit & adc_active);

   // Motor line is active low
   assign cas_play = ~cas_motor;

   // Back to tape start on menu request, new file, or reset
   assign cas_rewind = cfg.tape_rewind | cas_dl | core_reset;

   // Stall the loader at once while the buffer is busy
   assign ioctl_wait = cas_dl & ~cas_ready;

endmodule

//--- src/msx_video_cfg_top.sv
// MSX video configuration and tape routing top level
module msx_video_cfg_top #(
   parameter logic [12:0] ARX_NATIVE = msx_video_pkg::DEF_ARX_NATIVE,
   parameter logic [12:0] ARX_WIDE   = msx_video_pkg::DEF_ARX_WIDE,
   parameter logic [12:0] ARY_NATIVE = msx_video_pkg::DEF_ARY_NATIVE,
   parameter logic [5:0]  CAS_INDEX  = msx_video_pkg::DEF_CAS_INDEX
) (
   input  logic                                CLK_VIDEO,
   input  logic                                arst_n,
   // OSD menu and framework
   input  logic [msx_video_pkg::STATUS_W-1:0] status,
   input  logic                                forced_scandoubler,
   input  logic                                ext_reset,
   input  logic                                cart_reset,
   input  msx_video_pkg::hdmi_size_t           hdmi,
   // Loader
   input  logic                                ioctl_download,
   input  logic [5:0]                          ioctl_index,
   output logic                                ioctl_wait,
   // Cassette buffer, player and ADC
   input  logic                                cas_ready,
   input  logic                                cas_bit,
   input  logic                                adc_bit,
   input  logic                                adc_active,
   input  logic                                cas_motor,
   // Core side
   output logic                                core_reset,
   output logic                                tape_in,
   output logic                                cas_play,
   output logic                                cas_rewind,
   // Scaler side
   output msx_video_pkg::video_cfg_t           video_cfg
);

   import msx_video_pkg::*;

   osd_cfg_t cfg;
   crop_t    crop;

   // ======================================================================
   // Decode
   // ======================================================================

   osd_status_decode u_decode (
      .CLK_VIDEO          (CLK_VIDEO),
      .arst_n             (arst_n),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .ext_reset          (ext_reset),
      .cart_reset         (cart_reset),
      .cfg                (cfg),
      .core_reset         (core_reset)
   );

   // ======================================================================
   // Video path
   // ======================================================================

   crop_select u_crop (
      .CLK_VIDEO (CLK_VIDEO),
      .arst_n    (arst_n),
      .hdmi      (hdmi),
      .cfg       (cfg),
      .crop      (crop)
   );

   aspect_result #(
      .ARX_NATIVE (ARX_NATIVE),
      .ARX_WIDE   (ARX_WIDE),
      .ARY_NATIVE (ARY_NATIVE)
   ) u_aspect (
      .CLK_VIDEO (CLK_VIDEO),
      .arst_n    (arst_n),
      .crop      (crop),
      .cfg       (cfg),
      .video_cfg (video_cfg)
   );

   // Tape path, no clock
   tape_route #(
      .CAS_INDEX (CAS_INDEX)
   ) u_tape (
      .cfg            (cfg),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .cas_ready      (cas_ready),
      .cas_bit        (cas_bit),
      .adc_bit        (adc_bit),
      .adc_active     (adc_active),
      .cas_motor      (cas_motor),
      .core_reset     (core_reset),
      .tape_in        (tape_in),
      .cas_play       (cas_play),
      .cas_rewind     (cas_rewind),
      .ioctl_wait     (ioctl_wait)
   );

endmodule

//--- test/msx_video_cfg_props.sv
// Concurrent checks on core reset, loader wait and crop enable of the video config top
module msx_video_cfg_props #(
   parameter logic [5:0] CAS_INDEX = msx_video_pkg::DEF_CAS_INDEX
) (
   input  logic                                CLK_VIDEO,
   input  logic                                arst_n,
   input  logic [msx_video_pkg::STATUS_W-1:0] status,
   input  logic                                ioctl_download,
   input  logic [5:0]                          ioctl_index,
   input  logic                                ioctl_wait,
   input  logic                                core_reset,
   input  msx_video_pkg::video_cfg_t           video_cfg
);

   timeunit 1ns;
   timeprecision 1ps;

   import msx_video_pkg::*;

   // Failed assertions, read back by the testbench
   int unsigned fail_cnt = 0;

   // Core held in reset for the whole of arst_n
   a_reset_held: assert property (@(posedge CLK_VIDEO) !arst_n |-> core_reset)
      else begin
         $error("core_reset low while arst_n is asserted");
         fail_cnt++;
      end

   // Loader stalled only by a cassette download
   a_wait_cas_only: assert property (@(posedge CLK_VIDEO) disable iff (!arst_n)
      ioctl_wait |-> (ioctl_download && (ioctl_index == CAS_INDEX)))
      else begin
         $error("ioctl_wait high outside a cassette download");
         fail_cnt++;
      end

   // Crop off one register stage after vcrop is cleared
   a_crop_off: assert property (@(posedge CLK_VIDEO) disable iff (!arst_n)
      !status[7] |=> (video_cfg.crop_size == '0))
      else begin
         $error("crop_size not zero with vertical crop disabled");
         fail_cnt++;
      end

endmodule

bind msx_video_cfg_top msx_video_cfg_props #(
   .CAS_INDEX (CAS_INDEX)
) u_props (
   .CLK_VIDEO      (CLK_VIDEO),
   .arst_n         (arst_n),
   .status         (status),
   .ioctl_download (ioctl_download),
   .ioctl_index    (ioctl_index),
   .ioctl_wait     (ioctl_wait),
   .core_reset     (core_reset),
   .video_cfg      (video_cfg)
);

//--- test/tb_msx_video_cfg.sv
// Directed testbench for the MSX video configuration and tape routing top level
module tb_msx_video_cfg;

   timeunit 1ns;
   timeprecision 1ps;

   import msx_video_pkg::*;

   // Tests run about 100 cycles, limit leaves a wide margin
   localparam int unsigned MAX_CYCLES = 2000;
   localparam int unsigned TBL_N      = 7;

   logic                CLK_VIDEO;
   logic                arst_n;
   logic [STATUS_W-1:0] status;
   logic                forced_scandoubler;
   logic                ext_reset;
   logic                cart_reset;
   hdmi_size_t          hdmi;
   logic                ioctl_download;
   logic [5:0]          ioctl_index;
   logic                ioctl_wait;
   logic                cas_ready;
   logic                cas_bit;
   logic                adc_bit;
   logic                adc_active;
   logic                cas_motor;
   logic                core_reset;
   logic                tape_in;
   logic                cas_play;
   logic                cas_rewind;
   video_cfg_t          video_cfg;

   int unsigned cycle_cnt = 0;

   // Crop table for displays of at least 3:2
   int unsigned tbl_height [TBL_N] = '{480, 600, 720, 768, 800, 1080, 1200};
   int unsigned tbl_vcrop  [TBL_N] = '{240, 200, 240, 256, 200, 216, 240};
   // Narrow picture heights
   logic        tbl_wide   [TBL_N] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
   string       src_name   [4]     = '{"ext_reset", "status[0]", "status[10]", "cart_reset"};

   msx_video_cfg_top UUT (.*);

   initial begin
      CLK_VIDEO = 1'b0;
      forever #10 CLK_VIDEO = ~CLK_VIDEO;
   end

   // ======================================================================
   // Reporting and compare tasks
   // ======================================================================

   task automatic stop_on_error(string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   // Cycle limit and bound assertion watch
   always @(posedge CLK_VIDEO) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         stop_on_error("Timeout, the tests did not finish within the cycle limit");
      end else if (UUT.u_props.fail_cnt != 0) begin
         stop_on_error("A bound assertion failed");
      end
   end

   function automatic string fmt_video(video_cfg_t v);
      return $sformatf("arx %0d ary %0d crop %0d scale %0d lines %0d",
                       v.arx, v.ary, v.crop_size, v.scale, v.scanlines);
   endfunction

   task automatic check_video(string name, video_cfg_t exp, video_cfg_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("Mismatch in %s: expected %s, actual %s",
                                 name, fmt_video(exp), fmt_video(act)));
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp) begin
         stop_on_error($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   // ======================================================================
   // Stimulus helpers
   // ======================================================================

   // Menu bit layout: aspect 2:1, scanlines 4:3, scale 6:5, vcrop 7
   function automatic logic [STATUS_W-1:0] make_status(aspect_e ar, logic [1:0] lines,
                                                        scale_e sc, logic vcrop);
      logic [STATUS_W-1:0] s;
      s      = '0;
      s[2:1] = ar;
      s[4:3] = lines;
      s[6:5] = sc;
      s[7]   = vcrop;
      return s;
   endfunction

   function automatic video_cfg_t make_video(int unsigned arx, int unsigned ary,
                                             int unsigned crop, scale_e sc, logic [1:0] lines);
      video_cfg_t v;
      v.arx       = 13'(arx);
      v.ary       = 13'(ary);
      v.crop_size = 10'(crop);
      v.scale     = sc;
      v.scanlines = lines;
      return v;
   endfunction

   // Drive menu and display size, wait out both register stages
   task automatic apply_video(logic [STATUS_W-1:0] s, int unsigned w, int unsigned h,
                              logic forced);
      @(posedge CLK_VIDEO);
      status             <= s;
      hdmi.width         <= 12'(w);
      hdmi.height        <= 12'(h);
      forced_scandoubler <= forced;
      repeat (2) @(posedge CLK_VIDEO);
      @(negedge CLK_VIDEO);
   endtask

   task automatic set_reset_source(int unsigned which, logic v);
      case (which)
         0:       ext_reset  <= v;
         1:       status[0]  <= v;
         2:       status[10] <= v;
         default: cart_reset <= v;
      endcase
   endtask

   // ======================================================================
   // Tests
   // ======================================================================

   task automatic check_reset();
      repeat (3) @(posedge CLK_VIDEO);
      @(negedge CLK_VIDEO);
      check_video("reset video_cfg", '0, video_cfg);
      check_bit("reset core_reset", 1'b1, core_reset);
      @(posedge CLK_VIDEO);
      arst_n <= 1'b1;
      @(negedge CLK_VIDEO);
      check_bit("release core_reset held", 1'b1, core_reset);
      @(negedge CLK_VIDEO);
      check_bit("release core_reset low", 1'b0, core_reset);
      for (int unsigned i = 0; i < 4; i++) begin
         @(posedge CLK_VIDEO);
         set_reset_source(i, 1'b1);
         @(negedge CLK_VIDEO);
         check_bit({src_name[i], " rise late"}, 1'b0, core_reset);
         @(negedge CLK_VIDEO);
         check_bit({src_name[i], " rise"}, 1'b1, core_reset);
         @(posedge CLK_VIDEO);
         set_reset_source(i, 1'b0);
         @(negedge CLK_VIDEO);
         check_bit({src_name[i], " fall late"}, 1'b1, core_reset);
         @(negedge CLK_VIDEO);
         check_bit({src_name[i], " fall"}, 1'b0, core_reset);
      end
   endtask

   task automatic check_wide_displays();
      int unsigned idx;
      int unsigned arx;
      for (int n = 0; n < 8; n++) begin
         idx = $urandom % TBL_N;
         arx = tbl_wide[idx] ? 340 : 400;
         apply_video(make_status(AR_ORIGINAL, 2'd0, SCALE_NORMAL, 1'b1),
                     2 * tbl_height[idx], tbl_height[idx], 1'b0);
         check_video($sformatf("wide height %0d", tbl_height[idx]),
                     make_video(arx, 300, tbl_vcrop[idx], SCALE_NORMAL, 2'd0), video_cfg);
      end
   endtask

   task automatic check_other_displays();
      logic [STATUS_W-1:0] s;
      s = make_status(AR_ORIGINAL, 2'd0, SCALE_NORMAL, 1'b1);
      apply_video(s, 1920, 1440, 1'b0);
      check_video("1920x1440", make_video(400, 300, 240, SCALE_NORMAL, 2'd0), video_cfg);
      apply_video(s, 2048, 1536, 1'b0);
      check_video("2048x1536", make_video(400, 300, 256, SCALE_NORMAL, 2'd0), video_cfg);
      apply_video(s, 1920, 1000, 1'b0);
      check_video("unlisted height", make_video(400, 300, 0, SCALE_NORMAL, 2'd0), video_cfg);
      // Scandoubler path never cropped
      apply_video(make_status(AR_ORIGINAL, 2'd2, SCALE_NORMAL, 1'b1), 1920, 1080, 1'b0);
      check_video("scanlines on", make_video(400, 300, 0, SCALE_NORMAL, 2'd2), video_cfg);
      apply_video(s, 1280, 800, 1'b1);
      check_video("forced scandoubler", make_video(400, 300, 0, SCALE_NORMAL, 2'd0), video_cfg);
      apply_video(s, 1280, 800, 1'b0);
      check_video("scandoubler off", make_video(340, 300, 200, SCALE_NORMAL, 2'd0), video_cfg);
   endtask

   task automatic check_aspect_modes();
      for (int unsigned code = 1; code < 4; code++) begin
         apply_video(make_status(aspect_e'(code), 2'd0, SCALE_NORMAL, 1'b1), 1280, 800, 1'b0);
         check_video($sformatf("aspect code %0d", code),
                     make_video(code - 1, 0, 200, SCALE_NORMAL, 2'd0), video_cfg);
      end
      apply_video(make_status(AR_ORIGINAL, 2'd0, SCALE_NORMAL, 1'b1), 1280, 800, 1'b0);
      check_video("original wide", make_video(340, 300, 200, SCALE_NORMAL, 2'd0), video_cfg);
      apply_video(make_status(AR_ORIGINAL, 2'd0, SCALE_NORMAL, 1'b0), 1280, 800, 1'b0);
      check_video("vcrop off", make_video(400, 300, 0, SCALE_NORMAL, 2'd0), video_cfg);
      apply_video(make_status(AR_ORIGINAL, 2'd1, SCALE_WIDE_HVINT, 1'b1), 1280, 800, 1'b0);
      check_video("scale wide", make_video(400, 300, 0, SCALE_WIDE_HVINT, 2'd1), video_cfg);
      apply_video(make_status(AR_CUSTOM2, 2'd3, SCALE_NARROW_HVINT, 1'b0), 1280, 800, 1'b0);
      check_video("scale narrow", make_video(2, 0, 0, SCALE_NARROW_HVINT, 2'd3), video_cfg);
   endtask

   // Tape path is combinational, checked in the same cycle
   task automatic tape_case(string name, logic src, logic cbit, logic abit, logic aact,
                            logic motor, logic rew, logic dl, logic [5:0] idx, logic rdy,
                            logic exp_in, logic exp_play, logic exp_rew, logic exp_wait);
      @(posedge CLK_VIDEO);
      status[8]      <= src;
      status[9]      <= rew;
      cas_bit        <= cbit;
      adc_bit        <= abit;
      adc_active     <= aact;
      cas_motor      <= motor;
      ioctl_download <= dl;
      ioctl_index    <= idx;
      cas_ready      <= rdy;
      @(negedge CLK_VIDEO);
      check_bit({name, " tape_in"}, exp_in, tape_in);
      check_bit({name, " cas_play"}, exp_play, cas_play);
      check_bit({name, " cas_rewind"}, exp_rew, cas_rewind);
      check_bit({name, " ioctl_wait"}, exp_wait, ioctl_wait);
   endtask

   task automatic check_tape_routing();
      tape_case("file bit 1", 0, 1, 0, 0, 1, 0, 0, 6'd0, 1, 1, 0, 0, 0);
      tape_case("file bit 0", 0, 0, 1, 1, 1, 0, 0, 6'd0, 1, 0, 0, 0, 0);
      tape_case("adc active", 1, 0, 1, 1, 0, 0, 0, 6'd0, 1, 1, 1, 0, 0);
      tape_case("adc idle", 1, 1, 1, 0, 0, 0, 0, 6'd0, 1, 0, 1, 0, 0);
      tape_case("adc low", 1, 1, 0, 1, 0, 0, 0, 6'd0, 1, 0, 1, 0, 0);
      tape_case("menu rewind", 0, 0, 0, 0, 0, 1, 0, 6'd0, 1, 0, 1, 1, 0);
      tape_case("cas load busy", 0, 0, 0, 0, 0, 0, 1, 6'd8, 0, 0, 1, 1, 1);
      tape_case("cas load ready", 0, 0, 0, 0, 0, 0, 1, 6'd8, 1, 0, 1, 1, 0);
      tape_case("other load busy", 0, 0, 0, 0, 0, 0, 1, 6'd5, 0, 0, 1, 0, 0);
      tape_case("no load", 0, 0, 0, 0, 0, 0, 0, 6'd8, 0, 0, 1, 0, 0);
      // Rewind from core reset, one register stage behind ext_reset
      @(posedge CLK_VIDEO);
      ext_reset <= 1'b1;
      @(negedge CLK_VIDEO);
      @(negedge CLK_VIDEO);
      check_bit("core reset rewind", 1'b1, cas_rewind);
      @(posedge CLK_VIDEO);
      ext_reset <= 1'b0;
      @(negedge CLK_VIDEO);
      @(negedge CLK_VIDEO);
      check_bit("core reset rewind off", 1'b0, cas_rewind);
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================

   initial begin
      void'($urandom(13));
      arst_n             = 1'b1;
      status             = '0;
      forced_scandoubler = 1'b0;
      ext_reset          = 1'b0;
      cart_reset         = 1'b0;
      hdmi               = '0;
      ioctl_download     = 1'b0;
      ioctl_index        = '0;
      cas_ready          = 1'b0;
      cas_bit            = 1'b0;
      adc_bit            = 1'b0;
      adc_active         = 1'b0;
      cas_motor          = 1'b1;
      // Reset falling edge just after time zero
      #1;
      arst_n = 1'b0;
      check_reset();
      check_wide_displays();
      check_other_displays();
      check_aspect_modes();
      check_tape_routing();
      // Bound assertions count their own failures
      if (UUT.u_props.fail_cnt == 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         stop_on_error($sformatf("Assertion failures seen: %0d", UUT.u_props.fail_cnt));
      end
   end

endmodule

//--- sim.f
src/msx_video_pkg.sv
src/osd_status_decode.sv
src/crop_select.sv
src/aspect_result.sv
src/tape_route.sv
src/msx_video_cfg_top.sv
test/msx_video_cfg_props.sv
test/tb_msx_video_cfg.sv

//--- Bender.yml
package:
  name: msx_video_cfg

sources:
  - src/msx_video_pkg.sv
  - src/osd_status_decode.sv
  - src/crop_select.sv
  - src/aspect_result.sv
  - src/tape_route.sv
  - src/msx_video_cfg_top.sv
  - target: test
    files:
      - test/msx_video_cfg_props.sv
      - test/tb_msx_video_cfg.sv
